// ==== compile.f ====
hdl/cache_pkg.sv
hdl/cache_ctrl_fsm.sv
hdl/cache_line_store.sv
hdl/cache_top.sv
sim/slow_mem_model.sv
sim/tb_cache.sv

// ==== sim/tb_cache.sv ====
// Directed cache tests; addresses use tags below 8 so the 256-word shadow covers all of memory
`timescale 1ns/100ps

module tb_cache;

	import cache_pkg::*;

	// about 340 accesses of at most ~13 cycles each, with wide margin
	localparam int MAX_CYCLES = 20000;

	logic      clk;
	logic      rst_n;
	proc_req_t proc_req;
	logic      stall;
	word_t     rdata;
	mem_req_t  mem_req;
	line_t     mem_rdata;
	logic      mem_ready;

	// word-level model of memory contents, indexed by the low 8 address bits
	word_t       shadow [256];
	int          seed;
	int unsigned cycles = 0;

	cache_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_req_i   (proc_req),
		.proc_stall_o (stall),
		.proc_rdata_o (rdata),
		.mem_req_o    (mem_req),
		.mem_rdata_i  (mem_rdata),
		.mem_ready_i  (mem_ready)
	);

	slow_mem_model mem_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_req_i   (mem_req),
		.mem_rdata_o (mem_rdata),
		.mem_ready_o (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// reporting and compare tasks
	// --------------------------------------------------
	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			fail_stop($sformatf("timeout after %0d cycles with tests still running", cycles));
		end
	end

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			fail_stop($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		if (act !== exp) begin
			fail_stop($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			fail_stop($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	function automatic word_addr_t make_addr(input int t, input int i, input int o);
		return {tag_t'(t), index_t'(i), offset_t'(o)};
	endfunction

	// initial memory word, a function of the full in-range address
	function automatic word_t fill_word(input logic [7:0] wa);
		return {8'h5a, wa, ~wa, wa ^ 8'h3c};
	endfunction

	function automatic line_t fill_line(input line_addr_t la);
		line_t l;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			l[k*WORD_W +: WORD_W] = fill_word({la[5:0], offset_t'(k)});
		end
		return l;
	endfunction

	function automatic line_t shadow_line(input line_addr_t la);
		line_t l;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			l[k*WORD_W +: WORD_W] = shadow[{la[5:0], offset_t'(k)}];
		end
		return l;
	endfunction

	// returns at the sampling point of the request cycle
	task automatic drive_req(input logic is_write, input word_addr_t addr, input word_t wdata);
		@(posedge clk);
		#1;
		proc_req.read  = !is_write;
		proc_req.write = is_write;
		proc_req.addr  = addr;
		proc_req.wdata = wdata;
		#2;
	endtask

	task automatic wait_unstalled(output int waited);
		waited = 0;
		while (stall) begin
			@(posedge clk);
			#3;
			waited++;
			if (waited > 64) begin
				fail_stop("stall stayed high, the cache never finished the miss");
			end
		end
	endtask

	task automatic release_req();
		@(posedge clk);
		#1;
		proc_req = '0;
	endtask

	task automatic read_and_check(input string name, input word_addr_t addr, output int waited);
		drive_req(1'b0, addr, '0);
		wait_unstalled(waited);
		check_word($sformatf("%s @%h", name, addr), shadow[addr[7:0]], rdata);
		release_req();
	endtask

	task automatic write_word(input word_addr_t addr, input word_t data, output int waited);
		drive_req(1'b1, addr, data);
		wait_unstalled(waited);
		shadow[addr[7:0]] = data;
		release_req();
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset_state();
		int waited;
		#2;
		check_bit("reset mem read", 1'b0, mem_req.read);
		check_bit("reset mem write", 1'b0, mem_req.write);
		check_bit("reset stall", 1'b0, stall);
		check_word("idle rdata", '0, rdata);
		drive_req(1'b0, make_addr(0, 5, 0), '0);
		check_bit("first read stalls", 1'b1, stall);
		check_bit("mem read before edge", 1'b0, mem_req.read);
		@(posedge clk);
		#3;
		check_bit("mem read rises", 1'b1, mem_req.read);
		check_bit("no mem write on clean miss", 1'b0, mem_req.write);
		wait_unstalled(waited);
		check_word("first read data", shadow[make_addr(0, 5, 0)], rdata);
		release_req();
	endtask

	task automatic test_clean_miss_hit();
		int waited;
		read_and_check("clean miss read", make_addr(1, 2, 1), waited);
		check_bit("clean miss stalls", 1'b1, waited > 0);
		read_and_check("same line hit", make_addr(1, 2, 3), waited);
		check_bit("hit without stall", 1'b0, waited > 0);
	endtask

	task automatic test_write_hit();
		int         waited;
		word_addr_t a;
		a = make_addr(1, 2, 1);
		write_word(a, 32'hdead_beef, waited);
		check_bit("write hit without stall", 1'b0, waited > 0);
		read_and_check("read after write", a, waited);
		check_line("memory before eviction", fill_line(a[ADDR_W-1:OFFSET_W]),
			mem_i.read_line(a[ADDR_W-1:OFFSET_W]));
	endtask

	task automatic test_dirty_eviction();
		int         waited;
		line_addr_t old_la;
		old_la = line_addr_t'(make_addr(1, 2, 0) >> OFFSET_W);
		read_and_check("evicting read", make_addr(3, 2, 2), waited);
		check_line("written-back line", shadow_line(old_la), mem_i.read_line(old_la));
		read_and_check("old line refetched", make_addr(1, 2, 1), waited);
	endtask

	task automatic test_random_mix();
		int         waited;
		word_addr_t a;
		repeat (200) begin
			a = make_addr($unsigned($random(seed)) % 4, $unsigned($random(seed)) % 8,
				$unsigned($random(seed)) % 4);
			if ($random(seed) & 1) begin
				write_word(a, $random(seed), waited);
			end else begin
				read_and_check("random read", a, waited);
			end
		end
		for (int t = 0; t < 4; t++) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				for (int o = 0; o < WORDS_PER_LINE; o++) begin
					read_and_check("readback", make_addr(t, i, o), waited);
				end
			end
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		seed     = 32'hb54c;
		proc_req = '0;
		rst_n    = 1'b0;
		for (int w = 0; w < 256; w++) begin
			shadow[w] = fill_word(w[7:0]);
		end
		for (int la = 0; la < 64; la++) begin
			mem_i.preload(line_addr_t'(la), fill_line(line_addr_t'(la)));
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset_state();
		test_clean_miss_hit();
		test_write_hit();
		test_dirty_eviction();
		test_random_mix();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== sim/slow_mem_model.sv ====
// Behavioral line memory of 64 lines picked by the low 6 line-address bits, so tags above 7 alias
`timescale 1ns/100ps

module slow_mem_model (
	input  logic                clk,
	input  logic                rst_n,
	input  cache_pkg::mem_req_t mem_req_i,
	output cache_pkg::line_t    mem_rdata_o,
	output logic                mem_ready_o
);

	import cache_pkg::*;

	// cycles from request to ready
	localparam int LATENCY = 3;

	line_t       lines [64];
	int unsigned wait_cnt;

	// --------------------------------------------------
	// request handling
	// --------------------------------------------------

	// a request still high after the ready cycle counts as a new one
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wait_cnt    <= 0;
			mem_ready_o <= 1'b0;
			mem_rdata_o <= '0;
		end else begin
			mem_ready_o <= 1'b0;
			if ((mem_req_i.read || mem_req_i.write) && !mem_ready_o) begin
				if (wait_cnt == LATENCY - 1) begin
					wait_cnt    <= 0;
					mem_ready_o <= 1'b1;
					if (mem_req_i.write) begin
						lines[mem_req_i.addr[5:0]] <= mem_req_i.wdata;
					end else begin
						mem_rdata_o <= lines[mem_req_i.addr[5:0]];
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end else begin
				wait_cnt <= 0;
			end
		end
	end

	// --------------------------------------------------
	// backdoor access
	// --------------------------------------------------
	task automatic preload(input line_addr_t la, input line_t data);
		lines[la[5:0]] = data;
	endtask

	function automatic line_t read_line(input line_addr_t la);
		return lines[la[5:0]];
	endfunction

endmodule

// ==== hdl/cache_top.sv ====
// Data cache top that needs a held processor request and one ready pulse per memory request
`timescale 1ns/100ps

module cache_top (
	input  logic                 clk,
	input  logic                 rst_n,

	// --------------------------------------------------
	// processor port
	// --------------------------------------------------
	input  cache_pkg::proc_req_t proc_req_i,
	output logic                 proc_stall_o,
	output cache_pkg::word_t     proc_rdata_o,

	// --------------------------------------------------
	// memory port
	// --------------------------------------------------
	output cache_pkg::mem_req_t  mem_req_o,
	input  cache_pkg::line_t     mem_rdata_i,
	input  logic                 mem_ready_i
);

	import cache_pkg::*;

	// status from the store
	logic hit;
	logic dirty;

	// controller strobes
	logic mem_read;
	logic mem_write;
	logic word_we;
	logic refill_we;
	logic clean;

	word_t      store_rdata;
	line_addr_t mem_addr;
	line_t      victim_line;

	// --------------------------------------------------
	// miss controller
	// --------------------------------------------------
	cache_ctrl_fsm ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_read_i   (proc_req_i.read),
		.req_write_i  (proc_req_i.write),
		.hit_i        (hit),
		.dirty_i      (dirty),
		.mem_ready_i  (mem_ready_i),
		.proc_stall_o (proc_stall_o),
		.mem_read_o   (mem_read),
		.mem_write_o  (mem_write),
		.word_we_o    (word_we),
		.refill_we_o  (refill_we),
		.clean_o      (clean)
	);

	// --------------------------------------------------
	// line store
	// --------------------------------------------------
	cache_line_store store_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.addr_i        (proc_req_i.addr),
		.wdata_i       (proc_req_i.wdata),
		.word_we_i     (word_we),
		.refill_we_i   (refill_we),
		.clean_i       (clean),
		.refill_line_i (mem_rdata_i),
		.hit_o         (hit),
		.dirty_o       (dirty),
		.rdata_o       (store_rdata),
		.mem_addr_o    (mem_addr),
		.victim_line_o (victim_line)
	);

	// read data only shows on a read, zero when idle
	assign proc_rdata_o = proc_req_i.read ? store_rdata : '0;

	// memory request from controller flags and store address/data
	assign mem_req_o.read  = mem_read;
	assign mem_req_o.write = mem_write;
	assign mem_req_o.addr  = mem_addr;
	assign mem_req_o.wdata = victim_line;

endmodule

// ==== hdl/cache_line_store.sv ====
// Line arrays for 8 direct-mapped lines; tag and data are not reset, so only valid bits mark content
`timescale 1ns/100ps

module cache_line_store (
	input  logic                  clk,
	input  logic                  rst_n,

	// addressed word and store data
	input  cache_pkg::word_addr_t addr_i,
	input  cache_pkg::word_t      wdata_i,

	// update strobes from the controller
	input  logic                  word_we_i,
	input  logic                  refill_we_i,
	input  logic                  clean_i,
	input  cache_pkg::line_t      refill_line_i,

	// status and data of the addressed line
	output logic                  hit_o,
	output logic                  dirty_o,
	output cache_pkg::word_t      rdata_o,

	// memory side address and write-back data
	output cache_pkg::line_addr_t mem_addr_o,
	output cache_pkg::line_t      victim_line_o
);

	import cache_pkg::*;

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	tag_t  tag_mem  [NUM_LINES];
	line_t data_mem [NUM_LINES];

	logic [NUM_LINES-1:0] valid;
	logic [NUM_LINES-1:0] dirty;

	// address fields
	tag_t    req_tag;
	index_t  req_idx;
	offset_t req_off;

	line_t cur_line;
	line_t merged_line;

	assign req_tag = addr_i[ADDR_W-1 -: TAG_W];
	assign req_idx = addr_i[OFFSET_W +: INDEX_W];
	assign req_off = addr_i[OFFSET_W-1:0];

	assign cur_line = data_mem[req_idx];

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------
	assign hit_o   = valid[req_idx] && (tag_mem[req_idx] == req_tag);
	assign dirty_o = valid[req_idx] & dirty[req_idx];

	// word k at bits 32k
	assign rdata_o = cur_line[req_off*WORD_W +: WORD_W];

	// victim address only while a dirty line is being replaced
	always_comb begin
		if (dirty_o && !hit_o) begin
			mem_addr_o = {tag_mem[req_idx], req_idx};
		end else begin
			mem_addr_o = {req_tag, req_idx};
		end
	end

	assign victim_line_o = cur_line;

	// --------------------------------------------------
	// word merge
	// --------------------------------------------------
	always_comb begin
		merged_line = cur_line;
		for (int k = 0; k < WORDS_PER_LINE; k++) begin
			if (offset_t'(k) == req_off) begin
				merged_line[k*WORD_W +: WORD_W] = wdata_i;
			end
		end
	end

	// --------------------------------------------------
	// line updates
	// --------------------------------------------------

	// payload arrays
	always_ff @(posedge clk) begin
		if (refill_we_i) begin
			data_mem[req_idx] <= refill_line_i;
			tag_mem[req_idx]  <= req_tag;
		end else if (word_we_i) begin
			data_mem[req_idx] <= merged_line;
		end
	end

	// status bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (refill_we_i) begin
				// fresh copy of memory
				valid[req_idx] <= 1'b1;
				dirty[req_idx] <= 1'b0;
			end else if (word_we_i) begin
				dirty[req_idx] <= 1'b1;
			end else if (clean_i) begin
				dirty[req_idx] <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// controller writes words only into a resident line
	assert property (@(posedge clk) disable iff (!rst_n)
		word_we_i |-> hit_o)
	else $error("word write without a hit");

	// a refilled line hits on the next cycle, clean
	assert property (@(posedge clk) disable iff (!rst_n)
		refill_we_i |=> (hit_o && !dirty_o))
	else $error("refilled line does not hit clean");

endmodule

// ==== hdl/cache_ctrl_fsm.sv ====
// Miss controller that needs the processor to hold its request while stalled and one ready pulse
`timescale 1ns/100ps

module cache_ctrl_fsm (
	input  logic clk,
	input  logic rst_n,

	// processor request flags
	input  logic req_read_i,
	input  logic req_write_i,

	// status of the addressed line
	input  logic hit_i,
	input  logic dirty_i,

	// memory handshake
	input  logic mem_ready_i,

	output logic proc_stall_o,
	output logic mem_read_o,
	output logic mem_write_o,

	// one-cycle update strobes for the line store
	output logic word_we_o,
	output logic refill_we_o,
	output logic clean_o
);

	import cache_pkg::*;

	// --------------------------------------------------
	// state register
	// --------------------------------------------------
	cache_state_e state;
	cache_state_e state_nxt;

	logic req_active;
	logic miss;

	assign req_active = req_read_i | req_write_i;

	// only meaningful in S_COMPARE
	assign miss = req_active & ~hit_i;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_COMPARE;
		end else begin
			state <= state_nxt;
		end
	end

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			S_COMPARE: begin
				// victim must go out first if it holds modified words
				if (miss) begin
					if (dirty_i) begin
						state_nxt = S_WRITE_BACK;
					end else begin
						state_nxt = S_ALLOCATE;
					end
				end
			end
			S_WRITE_BACK: begin
				if (mem_ready_i) begin
					state_nxt = S_ALLOCATE;
				end
			end
			S_ALLOCATE: begin
				// request retried in compare, now a hit
				if (mem_ready_i) begin
					state_nxt = S_COMPARE;
				end
			end
			default: begin
				state_nxt = S_COMPARE;
			end
		endcase
	end

	// --------------------------------------------------
	// output decode
	// --------------------------------------------------
	always_comb begin
		proc_stall_o = 1'b0;
		mem_read_o   = 1'b0;
		mem_write_o  = 1'b0;
		word_we_o    = 1'b0;
		refill_we_o  = 1'b0;
		clean_o      = 1'b0;
		case (state)
			S_COMPARE: begin
				proc_stall_o = miss;
				word_we_o    = req_write_i & hit_i;
			end
			S_WRITE_BACK: begin
				proc_stall_o = 1'b1;
				mem_write_o  = 1'b1;
				// victim now matches memory
				clean_o      = mem_ready_i;
			end
			S_ALLOCATE: begin
				proc_stall_o = 1'b1;
				mem_read_o   = 1'b1;
				// line data valid only in the ready cycle
				refill_we_o  = mem_ready_i;
			end
			default: begin
				proc_stall_o = 1'b0;
			end
		endcase
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// memory sees one kind of request at a time
	assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read_o && mem_write_o))
	else $error("mem read and write high together");

	// refill only in a ready cycle, and the read is dropped right after
	assert property (@(posedge clk) disable iff (!rst_n)
		refill_we_o |-> mem_ready_i ##1 (!mem_read_o && state == S_COMPARE))
	else $error("refill strobe without ready or read held after refill");

	// a hit never stalls the processor
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_COMPARE && hit_i) |-> !proc_stall_o)
	else $error("stall raised on a hit");

endmodule

// ==== hdl/cache_pkg.sv ====
// Fixed geometry of 8 direct-mapped lines of 4 words with a 30-bit word address and no parameter override
package cache_pkg;

	// --------------------------------------------------
	// geometry
	// --------------------------------------------------
	localparam int WORD_W         = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int NUM_LINES      = 8;
	localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
	localparam int ADDR_W         = 30;

	// address split, tag on top
	localparam int OFFSET_W    = $clog2(WORDS_PER_LINE);
	localparam int INDEX_W     = $clog2(NUM_LINES);
	localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
	localparam int LINE_ADDR_W = TAG_W + INDEX_W;

	// --------------------------------------------------
	// data and address types
	// --------------------------------------------------
	typedef logic [WORD_W-1:0] word_t;

	// word k sits at bits 32k upward, here and on the memory bus
	typedef logic [LINE_W-1:0] line_t;

	// {tag, index, offset}
	typedef logic [ADDR_W-1:0] word_addr_t;

	typedef logic [TAG_W-1:0] tag_t;

	typedef logic [INDEX_W-1:0] index_t;

	typedef logic [OFFSET_W-1:0] offset_t;

	// {tag, index} of a whole line
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;

	// --------------------------------------------------
	// request bundles
	// --------------------------------------------------

	// processor side, held steady while stalled
	typedef struct packed {
		logic       read;
		logic       write;
		word_addr_t addr;
		word_t      wdata;
	} proc_req_t;

	// memory side, held until the ready pulse
	typedef struct packed {
		logic       read;
		logic       write;
		line_addr_t addr;
		line_t      wdata;
	} mem_req_t;

	// --------------------------------------------------
	// controller states
	// --------------------------------------------------

	// compare is the idle and hit state
	typedef enum logic [1:0] {
		S_COMPARE,
		S_WRITE_BACK,
		S_ALLOCATE
	} cache_state_e;

endpackage
